//--- include/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// ******************************
// Data memory sizing
// ******************************

// Data and address width.
`define MEM_XLEN 32

// Banks are selected by word-address bits 3:2.
`define MEM_NUM_BANKS 4
`define MEM_BANK_BITS $clog2(`MEM_NUM_BANKS)

// Words per bank. The whole memory is 1 KiB.
`define MEM_BANK_WORDS 64
`define MEM_BANK_AW $clog2(`MEM_BANK_WORDS)

`define MEM_ORDER_DEPTH 4  // Order queue entries and in-flight limit.

`endif

//--- logic/mem_pkg.sv
`default_nettype none

`include "mem_defines.svh"

package mem_pkg;

  // ******************************
  // Load/store operations
  // ******************************

  typedef enum logic [3:0] {
    lsu_lb   = 4'd0,
    lsu_lh   = 4'd1,
    lsu_lw   = 4'd2,
    lsu_lbu  = 4'd3,
    lsu_lhu  = 4'd4,
    lsu_sb   = 4'd5,
    lsu_sh   = 4'd6,
    lsu_sw   = 4'd7,
    lsu_none = 4'd8
  } lsu_op_t;

  // One operation from execute.
  typedef struct packed {
    logic                 load;
    logic                 store;
    logic                 fence;
    lsu_op_t              lsu_op;
    logic [`MEM_XLEN-1:0] address;  // Byte address.
    logic [`MEM_XLEN-1:0] sdata;
    logic [4:0]           waddr;
    logic [`MEM_XLEN-1:0] wdata;    // ALU result.
  } mem_exec_t;

  // ******************************
  // Bank traffic
  // ******************************

  // Echoed back by the bank so the load can be finished.
  typedef struct packed {
    logic [4:0] waddr;
    lsu_op_t    lsu_op;
    logic [1:0] offset;
  } mem_tag_t;

  typedef struct packed {
    logic [`MEM_XLEN-1:0] address;
    logic [`MEM_XLEN-1:0] wdata;  // Already in its byte lanes.
    logic [3:0]           wstrb;  // Zero for a load.
    mem_tag_t             tag;
  } mem_req_t;

  typedef struct packed {
    logic [`MEM_XLEN-1:0] rdata;
    mem_tag_t             tag;
  } mem_rsp_t;

  // Register-file write port.
  typedef struct packed {
    logic                 wren;
    logic [4:0]           waddr;
    logic [`MEM_XLEN-1:0] wdata;
  } reg_write_t;

endpackage

`default_nettype wire

//--- logic/lsu_align.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module lsu_align (
  input  mem_pkg::lsu_op_t     lsu_op,
  input  logic [1:0]           offset,
  input  logic [`MEM_XLEN-1:0] sdata,
  output logic [`MEM_XLEN-1:0] wdata,
  output logic [3:0]           wstrb,
  input  logic [`MEM_XLEN-1:0] rdata,
  output logic [`MEM_XLEN-1:0] ldata
);

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  // Store placement.
  always_comb begin
    wdata = sdata;
    wstrb = 4'b0000;
    case (lsu_op)
      mem_pkg::lsu_sb: begin
        wdata = {4{sdata[7:0]}};
        wstrb = 4'b0001 << offset;
      end
      mem_pkg::lsu_sh: begin
        wdata = {2{sdata[15:0]}};
        wstrb = offset[1] ? 4'b1100 : 4'b0011;
      end
      mem_pkg::lsu_sw: wstrb = 4'b1111;
      default: wstrb = 4'b0000;  // Loads write nothing.
    endcase
  end

  // Load extraction.
  always_comb begin
    case (offset)
      2'd0:    lane_byte = rdata[7:0];
      2'd1:    lane_byte = rdata[15:8];
      2'd2:    lane_byte = rdata[23:16];
      default: lane_byte = rdata[31:24];
    endcase
    lane_half = offset[1] ? rdata[31:16] : rdata[15:0];

    case (lsu_op)
      mem_pkg::lsu_lb:  ldata = {{24{lane_byte[7]}}, lane_byte};
      mem_pkg::lsu_lbu: ldata = {24'h0, lane_byte};
      mem_pkg::lsu_lh:  ldata = {{16{lane_half[15]}}, lane_half};
      mem_pkg::lsu_lhu: ldata = {16'h0, lane_half};
      default:          ldata = rdata;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module memory_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  mem_pkg::mem_exec_t   exec,
  input  logic                 exec_valid,
  output logic                 exec_ready,
  output mem_pkg::mem_req_t    req,
  output logic                 req_valid,
  input  logic                 req_ready,
  input  mem_pkg::mem_rsp_t    rsp,
  input  logic                 rsp_valid,
  output mem_pkg::reg_write_t  reg_write
);

  localparam int cnt_w = $clog2(`MEM_ORDER_DEPTH + 1);

  logic                 is_mem;
  logic                 is_alu;
  logic                 idle;
  logic                 full;
  logic                 issue;
  logic                 alu_fire;
  logic                 rsp_is_load;
  logic [cnt_w-1:0]     inflight;
  logic [`MEM_XLEN-1:0] st_wdata;
  logic [3:0]           st_wstrb;
  logic [`MEM_XLEN-1:0] ld_data;
  mem_pkg::reg_write_t  wb_next;

  lsu_align u_store_align (
    .lsu_op (exec.lsu_op),
    .offset (exec.address[1:0]),
    .sdata  (exec.sdata),
    .wdata  (st_wdata),
    .wstrb  (st_wstrb),
    .rdata  ('0),
    .ldata  ()
  );

  lsu_align u_load_align (
    .lsu_op (rsp.tag.lsu_op),
    .offset (rsp.tag.offset),
    .sdata  ('0),
    .wdata  (),
    .wstrb  (),
    .rdata  (rsp.rdata),
    .ldata  (ld_data)
  );

  // ******************************
  // Issue side
  // ******************************

  assign is_mem = exec.load | exec.store;
  assign is_alu = ~(exec.load | exec.store | exec.fence);
  assign idle   = (inflight == '0);
  assign full   = (inflight == cnt_w'(`MEM_ORDER_DEPTH));

  // Fences and ALU results wait until every access has returned.
  assign req_valid  = exec_valid & is_mem & ~full;
  assign exec_ready = is_mem ? (req_ready & ~full) : idle;
  assign issue      = req_valid & req_ready;
  assign alu_fire   = exec_valid & exec_ready & is_alu;

  always_comb begin
    req.address    = exec.address;
    req.wdata      = st_wdata;
    req.wstrb      = exec.load ? 4'b0000 : st_wstrb;
    req.tag.waddr  = exec.waddr;
    req.tag.lsu_op = exec.lsu_op;
    req.tag.offset = exec.address[1:0];
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      inflight <= '0;
    end else if (issue && !rsp_valid) begin
      inflight <= inflight + 1'b1;
    end else if (!issue && rsp_valid) begin
      inflight <= inflight - 1'b1;
    end
  end

  // ******************************
  // Writeback
  // ******************************

  assign rsp_is_load = rsp.tag.lsu_op inside {mem_pkg::lsu_lb, mem_pkg::lsu_lh,
                                              mem_pkg::lsu_lw, mem_pkg::lsu_lbu,
                                              mem_pkg::lsu_lhu};

  // A response never meets an ALU result. The ALU needs an idle stage.
  always_comb begin
    wb_next.wren  = 1'b0;
    wb_next.waddr = reg_write.waddr;
    wb_next.wdata = reg_write.wdata;
    if (rsp_valid && rsp_is_load) begin
      wb_next.wren  = |rsp.tag.waddr;  // x0 is never written.
      wb_next.waddr = rsp.tag.waddr;
      wb_next.wdata = ld_data;
    end else if (alu_fire) begin
      wb_next.wren  = |exec.waddr;
      wb_next.waddr = exec.waddr;
      wb_next.wdata = exec.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      reg_write.wren <= 1'b0;
    end else begin
      reg_write <= wb_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/bank_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module bank_router (
  input  mem_pkg::mem_req_t          req,
  input  logic                       req_valid,
  output logic                       req_ready,
  output mem_pkg::mem_req_t          bank_req,
  output logic [`MEM_NUM_BANKS-1:0]  bank_req_valid,
  input  logic [`MEM_NUM_BANKS-1:0]  bank_req_ready,
  output logic                       issue_valid,
  output logic [`MEM_BANK_BITS-1:0]  issue_bank,
  input  logic                       issue_ready
);

  logic [`MEM_BANK_BITS-1:0] bank_sel;
  logic                      sel_ready;

  // Low word-address bits pick the bank.
  assign bank_sel = req.address[2 +: `MEM_BANK_BITS];

  // All banks see the same request. Only one sees a valid.
  assign bank_req = req;

  always_comb begin
    for (int i = 0; i < `MEM_NUM_BANKS; i++) begin
      bank_req_valid[i] = req_valid && issue_ready &&
                          (bank_sel == `MEM_BANK_BITS'(i));
    end
  end

  assign sel_ready = bank_req_ready[bank_sel];

  // Both the bank and an order queue slot are needed.
  assign req_ready = sel_ready & issue_ready;

  // Recorded only when the request really transfers.
  assign issue_valid = req_valid & req_ready;
  assign issue_bank  = bank_sel;

endmodule

`default_nettype wire

//--- logic/data_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module data_bank (
  input  logic               clk,
  input  logic               rst,
  input  mem_pkg::mem_req_t  bank_req,
  input  logic               bank_req_valid,
  output logic               bank_req_ready,
  output mem_pkg::mem_rsp_t  bank_rsp,
  output logic               bank_rsp_valid,
  input  logic               bank_rsp_ready
);

  localparam int idx_lo = 2 + `MEM_BANK_BITS;
  localparam int nbytes = `MEM_XLEN / 8;

  logic [`MEM_XLEN-1:0]    mem [`MEM_BANK_WORDS];
  logic [`MEM_BANK_AW-1:0] idx;
  logic                    accept;

  // Word index sits above the byte and bank bits.
  assign idx = bank_req.address[idx_lo +: `MEM_BANK_AW];

  // A held response blocks the bank until the merge takes it.
  assign bank_req_ready = ~bank_rsp_valid | bank_rsp_ready;
  assign accept         = bank_req_valid & bank_req_ready;

  always_ff @(posedge clk) begin
    if (accept) begin
      for (int b = 0; b < nbytes; b++) begin
        if (bank_req.wstrb[b]) begin
          mem[idx][8*b +: 8] <= bank_req.wdata[8*b +: 8];
        end
      end
      bank_rsp.rdata <= mem[idx];  // Old word.
      bank_rsp.tag   <= bank_req.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      bank_rsp_valid <= 1'b0;
    end else if (accept) begin
      bank_rsp_valid <= 1'b1;
    end else if (bank_rsp_ready) begin
      bank_rsp_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/response_merge.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module response_merge (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         issue_valid,
  input  logic [`MEM_BANK_BITS-1:0]                    issue_bank,
  output logic                                         issue_ready,
  input  mem_pkg::mem_rsp_t [`MEM_NUM_BANKS-1:0]       bank_rsp,
  input  logic [`MEM_NUM_BANKS-1:0]                    bank_rsp_valid,
  output logic [`MEM_NUM_BANKS-1:0]                    bank_rsp_ready,
  output mem_pkg::mem_rsp_t                            rsp,
  output logic                                         rsp_valid
);

  localparam int ptr_w = $clog2(`MEM_ORDER_DEPTH);
  localparam int cnt_w = $clog2(`MEM_ORDER_DEPTH + 1);

  logic [`MEM_BANK_BITS-1:0] order_q [`MEM_ORDER_DEPTH];
  logic [ptr_w-1:0]          head;
  logic [ptr_w-1:0]          tail;
  logic [cnt_w-1:0]          count;
  logic [`MEM_BANK_BITS-1:0] head_bank;
  logic                      empty;

  assign empty       = (count == '0);
  assign issue_ready = (count != cnt_w'(`MEM_ORDER_DEPTH));
  assign head_bank   = order_q[head];

  // Only the oldest bank may hand over its response.
  always_comb begin
    for (int i = 0; i < `MEM_NUM_BANKS; i++) begin
      bank_rsp_ready[i] = ~empty && (head_bank == `MEM_BANK_BITS'(i));
    end
  end

  assign rsp       = bank_rsp[head_bank];
  assign rsp_valid = ~empty & bank_rsp_valid[head_bank];

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      order_q[tail] <= issue_bank;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (issue_valid) tail <= tail + 1'b1;  // Depth is a power of two.
      if (rsp_valid) head <= head + 1'b1;
      if (issue_valid && !rsp_valid) count <= count + 1'b1;
      else if (!issue_valid && rsp_valid) count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/mem_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module mem_subsystem_top (
  input  logic                 clk,
  input  logic                 rst,
  input  mem_pkg::mem_exec_t   exec,
  input  logic                 exec_valid,
  output logic                 exec_ready,
  output mem_pkg::reg_write_t  reg_write
);

  mem_pkg::mem_req_t                         req;
  logic                                      req_valid;
  logic                                      req_ready;
  mem_pkg::mem_rsp_t                         rsp;
  logic                                      rsp_valid;
  mem_pkg::mem_req_t                         bank_req;
  logic [`MEM_NUM_BANKS-1:0]                 bank_req_valid;
  logic [`MEM_NUM_BANKS-1:0]                 bank_req_ready;
  mem_pkg::mem_rsp_t [`MEM_NUM_BANKS-1:0]    bank_rsp;
  logic [`MEM_NUM_BANKS-1:0]                 bank_rsp_valid;
  logic [`MEM_NUM_BANKS-1:0]                 bank_rsp_ready;
  logic                                      issue_valid;
  logic [`MEM_BANK_BITS-1:0]                 issue_bank;
  logic                                      issue_ready;

  memory_stage u_stage (
    .clk, .rst, .exec, .exec_valid, .exec_ready,
    .req, .req_valid, .req_ready, .rsp, .rsp_valid, .reg_write
  );

  bank_router u_router (
    .req, .req_valid, .req_ready, .bank_req, .bank_req_valid, .bank_req_ready,
    .issue_valid, .issue_bank, .issue_ready
  );

  // ******************************
  // Interleaved banks
  // ******************************
  for (genvar i = 0; i < `MEM_NUM_BANKS; i++) begin : g_bank
    data_bank u_bank (
      .clk            (clk),
      .rst            (rst),
      .bank_req       (bank_req),
      .bank_req_valid (bank_req_valid[i]),
      .bank_req_ready (bank_req_ready[i]),
      .bank_rsp       (bank_rsp[i]),
      .bank_rsp_valid (bank_rsp_valid[i]),
      .bank_rsp_ready (bank_rsp_ready[i])
    );
  end

  response_merge u_merge (
    .clk, .rst, .issue_valid, .issue_bank, .issue_ready,
    .bank_rsp, .bank_rsp_valid, .bank_rsp_ready, .rsp, .rsp_valid
  );

endmodule

`default_nettype wire

//--- testbench/mem_subsystem_sva.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module mem_subsystem_sva (
  input logic                      clk,
  input logic                      rst,
  input mem_pkg::mem_req_t         req,
  input logic                      req_valid,
  input logic                      req_ready,
  input logic                      rsp_valid,
  input logic [`MEM_NUM_BANKS-1:0] bank_rsp_valid,
  input mem_pkg::reg_write_t       reg_write
);

  // Register 0 is never written.
  no_x0_write: assert property (@(posedge clk) disable iff (!rst)
    reg_write.wren |-> reg_write.waddr != 5'd0)
    else $error("register write carries register 0");

  req_stable: assert property (@(posedge clk) disable iff (!rst)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else $error("request dropped or changed while refused");  // Held until taken.

  // ******************************
  // Reset exit
  // ******************************

  quiet_after_reset: assert property (@(posedge clk)
    $rose(rst) |-> !reg_write.wren && !req_valid && !rsp_valid && bank_rsp_valid == '0)
    else $error("valid signal high in the first cycle after reset");

endmodule

bind mem_subsystem_top mem_subsystem_sva u_sva (
  .clk            (clk),
  .rst            (rst),
  .req            (req),
  .req_valid      (req_valid),
  .req_ready      (req_ready),
  .rsp_valid      (rsp_valid),
  .bank_rsp_valid (bank_rsp_valid),
  .reg_write      (reg_write)
);

`default_nettype wire

//--- testbench/mem_subsystem_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module mem_subsystem_tb;

  localparam int    ready_limit = 100;
  localparam int    drain_limit = 400;
  localparam string test_file   = "testbench/mem_tests.txt";

  logic                clk;
  logic                rst;
  mem_pkg::mem_exec_t  exec;
  logic                exec_valid;
  logic                exec_ready;
  mem_pkg::reg_write_t reg_write;

  // Expected writes in issue order.
  string       exp_name [$];
  logic [4:0]  exp_waddr [$];
  logic [31:0] exp_wdata [$];
  int          errors    = 0;
  int          writes    = 0;
  logic        timed_out = 1'b0;

  mem_subsystem_top dut (
    .clk, .rst, .exec, .exec_valid, .exec_ready, .reg_write
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ******************************
  // Write-back checking
  // ******************************

  task automatic check_write();
    string       name;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    writes++;
    assert (exp_name.size() > 0) else begin
      errors++;
      $display("Unexpected register write to x%0d with %08h.",
               reg_write.waddr, reg_write.wdata);
    end
    if (exp_name.size() > 0) begin
      name  = exp_name.pop_front();
      waddr = exp_waddr.pop_front();
      wdata = exp_wdata.pop_front();
      assert (reg_write.waddr === waddr && reg_write.wdata === wdata) else begin
        errors++;
        $display("MISMATCH %s expected x%0d=%08h actual x%0d=%08h",
                 name, waddr, wdata, reg_write.waddr, reg_write.wdata);
      end
    end
  endtask

  // Outputs change on the rising edge, so sample on the falling one.
  always @(negedge clk) begin
    if (!rst) begin
      assert (reg_write.wren === 1'b0) else begin
        errors++;
        $display("Register write pulse seen during reset.");
      end
    end else if (reg_write.wren === 1'b1) begin
      check_write();
    end
  end

  // ******************************
  // Stimulus
  // ******************************

  task automatic issue_op(input string name, input string kind, input logic [3:0] op,
                          input logic [31:0] addr, input logic [31:0] sdata,
                          input logic [4:0] waddr, input logic [31:0] alu);
    int wait_cycles;
    exec.load    = (kind == "ld");
    exec.store   = (kind == "st");
    exec.fence   = (kind == "fence");
    exec.lsu_op  = mem_pkg::lsu_op_t'(op);
    exec.address = addr;
    exec.sdata   = sdata;
    exec.waddr   = waddr;
    exec.wdata   = alu;
    exec_valid   = 1'b1;
    wait_cycles  = 0;
    #1;
    while (exec_ready !== 1'b1 && wait_cycles < ready_limit) begin
      @(negedge clk);
      #1;
      wait_cycles++;
    end
    if (exec_ready !== 1'b1) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: %s was not accepted within %0d cycles.", name, ready_limit);
    end
    @(negedge clk);  // Accepted on the edge in between.
    exec_valid = 1'b0;
  endtask

  initial begin
    int          fd;
    int          gap;
    int          fields;
    int          exp_wr;
    int          drain;
    string       line;
    string       name;
    string       kind;
    logic [3:0]  op;
    logic [31:0] addr;
    logic [31:0] sdata;
    logic [4:0]  waddr;
    logic [31:0] alu;
    logic [31:0] exp_data;
    void'($urandom(32'h6db7_419d));
    rst        = 1'b0;
    exec       = '0;
    exec_valid = 1'b0;
    fd = $fopen(test_file, "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open stimulus file %s.", test_file);
    end
    repeat (8) @(negedge clk);
    rst = 1'b1;
    @(negedge clk);

    while (fd != 0 && !timed_out && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n") continue;
      fields = $sscanf(line, "%s %s %h %h %h %d %h %d %h", name, kind, op, addr,
                       sdata, waddr, alu, exp_wr, exp_data);
      if (fields != 9) begin
        errors++;
        $display("Malformed stimulus line: %s", line);
        continue;
      end
      if (exp_wr != 0) begin
        exp_name.push_back(name);
        exp_waddr.push_back(waddr);
        exp_wdata.push_back(exp_data);
      end
      // Loads and ALU results follow at once so that accesses overlap.
      if (kind == "ld" || kind == "alu") begin
        gap = 0;
      end else begin
        gap = $urandom % 4;
      end
      repeat (gap) @(negedge clk);
      issue_op(name, kind, op, addr, sdata, waddr, alu);
    end

    drain = 0;
    while (!timed_out && exp_name.size() > 0 && drain < drain_limit) begin
      @(negedge clk);
      drain++;
    end
    if (exp_name.size() > 0) begin
      errors++;
      $display("Timeout: %0d expected writes never appeared.", exp_name.size());
    end
    repeat (10) @(negedge clk);  // Room for stray write pulses.

    $display("Checked %0d register writes, %0d errors.", writes, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
logic/mem_pkg.sv
logic/lsu_align.sv
logic/memory_stage.sv
logic/bank_router.sv
logic/data_bank.sv
logic/response_merge.sv
logic/mem_subsystem_top.sv
testbench/mem_subsystem_sva.sv
testbench/mem_subsystem_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mem_subsystem_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/mem_tests.txt
# name kind lsu_op addr sdata waddr alu_data exp_wr exp_data (waddr, exp_wr decimal; rest hex)
# kind: ld st fence alu. lsu_op: 0 lb 1 lh 2 lw 3 lbu 4 lhu 5 sb 6 sh 7 sw 8 none
st_word        st    7 100 deadbeef 0  00000000 0 00000000
ld_word        ld    2 100 00000000 1  00000000 1 deadbeef
st_base        st    7 104 11223344 0  00000000 0 00000000
st_byte        st    5 105 000000a5 0  00000000 0 00000000
st_half        st    6 106 00008001 0  00000000 0 00000000
ld_merged      ld    2 104 00000000 2  00000000 1 8001a544
ld_lb          ld    0 105 00000000 3  00000000 1 ffffffa5
ld_lbu         ld    3 105 00000000 4  00000000 1 000000a5
ld_lh          ld    1 106 00000000 5  00000000 1 ffff8001
ld_lhu         ld    4 106 00000000 6  00000000 1 00008001
ld_lb_pos      ld    0 104 00000000 7  00000000 1 00000044
ld_lh_low      ld    1 104 00000000 8  00000000 1 ffffa544
st_bank0       st    7 200 a0a0a000 0  00000000 0 00000000
st_bank1       st    7 204 b1b1b101 0  00000000 0 00000000
st_bank2       st    7 208 c2c2c202 0  00000000 0 00000000
st_bank3       st    7 20c d3d3d303 0  00000000 0 00000000
ld_bank0       ld    2 200 00000000 10 00000000 1 a0a0a000
ld_bank1       ld    2 204 00000000 11 00000000 1 b1b1b101
ld_bank2       ld    2 208 00000000 12 00000000 1 c2c2c202
ld_bank3       ld    2 20c 00000000 13 00000000 1 d3d3d303
ld_bank0_again ld    2 200 00000000 14 00000000 1 a0a0a000
ld_bank1_again ld    2 204 00000000 15 00000000 1 b1b1b101
ld_pending_a   ld    2 208 00000000 16 00000000 1 c2c2c202
ld_pending_b   ld    0 20c 00000000 17 00000000 1 00000003
alu_after_ld   alu   8 000 00000000 18 12345678 1 12345678
alu_x0         alu   8 000 00000000 0  55555555 0 00000000
ld_x0          ld    2 200 00000000 0  00000000 0 00000000
st_fence_src   st    7 300 cafef00d 0  00000000 0 00000000
fence_mid      fence 8 000 00000000 0  00000000 0 00000000
ld_after_fence ld    2 300 00000000 20 00000000 1 cafef00d
alu_last       alu   8 000 00000000 21 0000abcd 1 0000abcd
